// File: dv/jbb_tb.sv
`timescale 1ns/10ps

module jbb_tb;

	import jbb_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int PARTIAL_N = 40;
	localparam int ALIAS_N = 4;
	localparam int RANDOM_N = 300;
	// reset reads, fill and readback, partial pairs, alias groups, random mix
	localparam int XFER_N = REGS_N + 2 * RAM_DEPTH + 2 * PARTIAL_N + 5 * ALIAS_N + RANDOM_N;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * XFER_N;

	logic clk;
	logic reset;
	addr_t adr_i;
	data_t dat_i;
	logic we_i;
	sel_t sel_i;
	logic stb_i;
	data_t dat_o;
	logic ack_o;

	// shadow copies of both slaves
	data_t ram_model [RAM_DEPTH];
	data_t reg_model [REGS_N];

	logic [31:0] rng_state;
	int errors;
	int ack_count;
	int xfer_count;
	logic ack_prev;

	jbb_top dut (
		.clk(clk),
		.reset(reset),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.we_i(we_i),
		.sel_i(sel_i),
		.stb_i(stb_i),
		.dat_o(dat_o),
		.ack_o(ack_o)
	);

	always #5 clk = ~clk;

	// --------------------
	// reference model
	// --------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// every address bit shows up in the word
	function automatic data_t fill_word(input addr_t a);
		return {a, ~a, a, 2'b01} ^ 32'hc35a_0f96;
	endfunction

	function automatic data_t byte_merge(input data_t old_word, input data_t new_word,
			input sel_t sel);
		data_t r;
		r = old_word;
		for (int i = 0; i < SEL_W; i++) begin
			if (sel[i]) begin
				r[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return r;
	endfunction

	function automatic data_t expected_read(input addr_t a);
		if (a[SLAVE_BIT]) begin
			return reg_model[a[1:0]];
		end
		return ram_model[a[7:0]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("** Error %s at %0t: expected 0x%08h, actual 0x%08h",
				name, $time, expected, actual);
		end
	endtask

	// --------------------
	// WISHBONE master
	// --------------------

	// request held until ack is seen, next one follows in the same edge
	task automatic wb_access(input addr_t a, input data_t d, input logic w, input sel_t s);
		adr_i <= a;
		dat_i <= d;
		we_i <= w;
		sel_i <= s;
		stb_i <= 1'b1;
		xfer_count++;
		do @(posedge clk); while (!ack_o);
	endtask

	task automatic write_word(input addr_t a, input data_t d, input sel_t s);
		wb_access(a, d, 1'b1, s);
	endtask

	task automatic read_word(input addr_t a);
		wb_access(a, '0, 1'b0, 4'hf);
	endtask

	task automatic bus_idle();
		stb_i <= 1'b0;
		@(posedge clk);
	endtask

	// --------------------
	// ack monitor and checker
	// --------------------

	// adr_i and friends still show the acked request at this edge
	always @(posedge clk) begin
		if (!reset && ack_o) begin
			ack_count++;
			if (!stb_i) begin
				errors++;
				$display("Error at %0t: ack_o arrived with no request on stb_i", $time);
			end
			if (ack_prev) begin
				errors++;
				$display("Error at %0t: ack_o stayed high for two cycles", $time);
			end
			if (we_i) begin
				if (adr_i[SLAVE_BIT]) begin
					reg_model[adr_i[1:0]] = byte_merge(reg_model[adr_i[1:0]], dat_i, sel_i);
				end else begin
					ram_model[adr_i[7:0]] = byte_merge(ram_model[adr_i[7:0]], dat_i, sel_i);
				end
			end else begin
				check_value("dat_o", expected_read(adr_i), dat_o);
			end
		end
		ack_prev = ack_o;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired: ack_o never arrived for transfer %0d", xfer_count);
		$display("TESTS FAILED");
		$finish;
	end

	// --------------------
	// stimulus
	// --------------------

	initial begin
		addr_t a;
		data_t d;
		sel_t s;
		clk = 1'b0;
		reset = 1'b1;
		adr_i = '0;
		dat_i = '0;
		we_i = 1'b0;
		sel_i = '0;
		stb_i = 1'b0;
		errors = 0;
		ack_count = 0;
		xfer_count = 0;
		ack_prev = 1'b0;
		rng_state = 32'ha7a1_fd85;
		for (int i = 0; i < REGS_N; i++) begin
			reg_model[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// scratch block comes out of reset cleared
		for (int i = 0; i < REGS_N; i++) begin
			read_word(addr_t'(10'h200 + i));
		end
		bus_idle();

		// full-word fill, then read everything back
		for (int i = 0; i < RAM_DEPTH; i++) begin
			write_word(addr_t'(i), fill_word(addr_t'(i)), 4'hf);
		end
		for (int i = 0; i < RAM_DEPTH; i++) begin
			read_word(addr_t'(i));
		end
		bus_idle();

		// partial writes to either slave
		for (int i = 0; i < PARTIAL_N; i++) begin
			rng_state = lcg_next(rng_state);
			a = rng_state[25:16];
			s = rng_state[7:4];
			rng_state = lcg_next(rng_state);
			d = rng_state;
			write_word(a, d, s);
			read_word(a);
		end
		bus_idle();

		// register aliases and isolation between the two slaves
		for (int i = 0; i < ALIAS_N; i++) begin
			write_word(addr_t'(10'h3fc + i), 32'h1234_5678 ^ 32'(i), 4'hf);
			read_word(addr_t'(10'h200 + i));
			read_word(addr_t'(10'h0fc + i));
			write_word(addr_t'(i), 32'hfeed_0000 | 32'(i), 4'hf);
			read_word(addr_t'(10'h204 + i));
		end
		bus_idle();

		// random mix, mostly back to back
		for (int i = 0; i < RANDOM_N; i++) begin
			rng_state = lcg_next(rng_state);
			a = rng_state[25:16];
			s = rng_state[11:8];
			if (rng_state[31]) begin
				rng_state = lcg_next(rng_state);
				d = rng_state;
				write_word(a, d, s);
			end else begin
				read_word(a);
			end
			if (rng_state[29:28] == 2'b00) begin
				bus_idle();
			end
		end
		bus_idle();
		repeat (4) @(posedge clk);

		check_value("ack count", 32'(xfer_count), 32'(ack_count));
		$display("errors: %0d, transfers: %0d, acks: %0d", errors, xfer_count, ack_count);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: jbb.f
verilog/jbb_pkg.sv
verilog/jbb_bridge_ctrl.sv
verilog/jbb_req_reg.sv
verilog/jbb_decode.sv
verilog/jbb_word_ram.sv
verilog/jbb_scratch_regs.sv
verilog/jbb_top.sv
dv/jbb_tb.sv

// File: run.sh
#!/bin/sh
# build and run the WISHBONE bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module jbb_tb -f jbb.f -o jbb_sim

./obj_dir/jbb_sim | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
	exit 0
else
	echo "simulation reported failure, see sim.log"
	exit 1
fi

// File: verilog/jbb_bridge_ctrl.sv
`timescale 1ns/10ps

module jbb_bridge_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic stb_i,
	input  logic we_i,
	input  logic bus_ready_i,
	output logic load_o,
	output logic capture_o,
	output logic bus_valid_o,
	output logic ack_o
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		RDATA,
		ACK
	} state_t;

	state_t state;
	state_t state_next;

	// --------------------
	// transaction sequencing
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (stb_i) begin
					state_next = REQ;
				end
			end
			REQ: begin
				// writes finish on acceptance, reads wait for data
				if (bus_ready_i) begin
					state_next = we_i ? ACK : RDATA;
				end
			end
			RDATA: begin
				if (bus_ready_i) begin
					state_next = ACK;
				end
			end
			// strobe may still be high here, so never restart from ACK
			ACK: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	// --------------------
	// outputs
	// --------------------

	assign load_o = (state == IDLE) && stb_i;
	assign bus_valid_o = (state == REQ);
	// slave holds read data until the next acceptance
	assign capture_o = (state == RDATA) && bus_ready_i;
	assign ack_o = (state == ACK);

	// one ack per transfer, even with a strobe held across transfers
	a_ack_single: assert property (
		@(posedge clk) disable iff (reset) ack_o |=> !ack_o
	);

	// request stays up through any slave wait cycles
	a_valid_hold: assert property (
		@(posedge clk) disable iff (reset) bus_valid_o && !bus_ready_i |=> bus_valid_o
	);

endmodule

// File: verilog/jbb_decode.sv
`timescale 1ns/10ps

module jbb_decode (
	input  logic clk,
	input  logic reset,
	input  logic bus_valid_i,
	input  jbb_pkg::addr_t bus_addr_i,
	input  logic ram_ready_i,
	input  logic reg_ready_i,
	input  jbb_pkg::data_t ram_rdata_i,
	input  jbb_pkg::data_t reg_rdata_i,
	output logic ram_valid_o,
	output logic reg_valid_o,
	output logic bus_ready_o,
	output jbb_pkg::data_t bus_rdata_o
);

	import jbb_pkg::*;

	logic reg_sel;
	logic last_reg_q;

	// --------------------
	// request routing
	// --------------------

	assign reg_sel = bus_addr_i[SLAVE_BIT];

	assign ram_valid_o = bus_valid_i && !reg_sel;
	assign reg_valid_o = bus_valid_i && reg_sel;

	// ready comes from whichever slave the address points at
	assign bus_ready_o = reg_sel ? reg_ready_i : ram_ready_i;

	// --------------------
	// read return
	// --------------------

	// remember which slave took the last request
	always_ff @(posedge clk) begin
		if (reset) begin
			last_reg_q <= 1'b0;
		end else if (bus_valid_i && bus_ready_o) begin
			last_reg_q <= reg_sel;
		end
	end

	assign bus_rdata_o = last_reg_q ? reg_rdata_i : ram_rdata_i;

	a_one_slave: assert property (
		@(posedge clk) disable iff (reset) !(ram_valid_o && reg_valid_o)
	);

endmodule

// File: verilog/jbb_pkg.sv
package jbb_pkg;

	// --------------------
	// bus widths
	// --------------------

	// word address on both buses
	localparam int ADDR_W = 10;
	localparam int DATA_W = 32;
	// one select per byte lane
	localparam int SEL_W = 4;

	// --------------------
	// address map
	// --------------------

	localparam int RAM_DEPTH = 256;
	localparam int REGS_N = 4;
	// low half of the map is the memory, upper half the scratch block
	localparam int SLAVE_BIT = 9;

	// --------------------
	// vector types
	// --------------------

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;

endpackage

// File: verilog/jbb_req_reg.sv
`timescale 1ns/10ps

module jbb_req_reg (
	input  logic clk,
	input  logic load_i,
	input  logic capture_i,
	input  jbb_pkg::addr_t adr_i,
	input  jbb_pkg::data_t dat_i,
	input  logic we_i,
	input  jbb_pkg::sel_t sel_i,
	input  jbb_pkg::data_t bus_rdata_i,
	output jbb_pkg::addr_t bus_addr_o,
	output jbb_pkg::data_t bus_wdata_o,
	output logic bus_we_o,
	output jbb_pkg::sel_t bus_sel_o,
	output jbb_pkg::data_t dat_o
);

	// request side, held for the whole internal transfer
	always_ff @(posedge clk) begin
		if (load_i) begin
			bus_addr_o <= adr_i;
			bus_wdata_o <= dat_i;
			bus_we_o <= we_i;
			bus_sel_o <= sel_i;
		end
	end

	// read return, stays valid past the ack
	always_ff @(posedge clk) begin
		if (capture_i) begin
			dat_o <= bus_rdata_i;
		end
	end

	// master must present a clean request when the bridge picks it up
	a_load_known: assert property (
		@(posedge clk) load_i |-> !$isunknown({adr_i, dat_i, we_i, sel_i})
	);

endmodule

// File: verilog/jbb_scratch_regs.sv
`timescale 1ns/10ps

module jbb_scratch_regs (
	input  logic clk,
	input  logic reset,
	input  logic valid_i,
	input  jbb_pkg::addr_t addr_i,
	input  logic we_i,
	input  jbb_pkg::sel_t sel_i,
	input  jbb_pkg::data_t wdata_i,
	output logic ready_o,
	output jbb_pkg::data_t rdata_o
);

	import jbb_pkg::*;

	data_t regs [REGS_N];
	logic [$clog2(REGS_N)-1:0] reg_idx;
	logic wait_q;
	logic accept;

	// upper address bits ignored, so the block repeats every four words
	assign reg_idx = addr_i[$clog2(REGS_N)-1:0];

	assign ready_o = !wait_q;
	assign accept = valid_i && ready_o;

	// --------------------
	// wait state
	// --------------------

	// stall one cycle behind every access
	always_ff @(posedge clk) begin
		if (reset) begin
			wait_q <= 1'b0;
		end else begin
			wait_q <= accept;
		end
	end

	// --------------------
	// register file
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REGS_N; i++) begin
				regs[i] <= '0;
			end
		end else if (accept && we_i) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (sel_i[i]) begin
					regs[reg_idx][8*i +: 8] <= wdata_i[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !we_i) begin
			rdata_o <= regs[reg_idx];
		end
	end

	// every accepted access is followed by exactly one stalled cycle
	a_wait_after_accept: assert property (
		@(posedge clk) disable iff (reset) accept |=> wait_q && !accept
	);

endmodule

// File: verilog/jbb_top.sv
`timescale 1ns/10ps

module jbb_top (
	input  logic clk,
	input  logic reset,
	input  jbb_pkg::addr_t adr_i,
	input  jbb_pkg::data_t dat_i,
	input  logic we_i,
	input  jbb_pkg::sel_t sel_i,
	input  logic stb_i,
	output jbb_pkg::data_t dat_o,
	output logic ack_o
);

	import jbb_pkg::*;

	// --------------------
	// bridge internals
	// --------------------

	logic load;
	logic capture;

	// internal bus
	logic bus_valid;
	logic bus_ready;
	addr_t bus_addr;
	data_t bus_wdata;
	logic bus_we;
	sel_t bus_sel;
	data_t bus_rdata;

	// per-slave handshakes
	logic ram_valid;
	logic ram_ready;
	data_t ram_rdata;
	logic reg_valid;
	logic reg_ready;
	data_t reg_rdata;

	jbb_bridge_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.stb_i(stb_i),
		.we_i(we_i),
		.bus_ready_i(bus_ready),
		.load_o(load),
		.capture_o(capture),
		.bus_valid_o(bus_valid),
		.ack_o(ack_o)
	);

	jbb_req_reg u_req (
		.clk(clk),
		.load_i(load),
		.capture_i(capture),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.we_i(we_i),
		.sel_i(sel_i),
		.bus_rdata_i(bus_rdata),
		.bus_addr_o(bus_addr),
		.bus_wdata_o(bus_wdata),
		.bus_we_o(bus_we),
		.bus_sel_o(bus_sel),
		.dat_o(dat_o)
	);

	// --------------------
	// slave side
	// --------------------

	jbb_decode u_decode (
		.clk(clk),
		.reset(reset),
		.bus_valid_i(bus_valid),
		.bus_addr_i(bus_addr),
		.ram_ready_i(ram_ready),
		.reg_ready_i(reg_ready),
		.ram_rdata_i(ram_rdata),
		.reg_rdata_i(reg_rdata),
		.ram_valid_o(ram_valid),
		.reg_valid_o(reg_valid),
		.bus_ready_o(bus_ready),
		.bus_rdata_o(bus_rdata)
	);

	jbb_word_ram u_ram (
		.clk(clk),
		.valid_i(ram_valid),
		.addr_i(bus_addr),
		.we_i(bus_we),
		.sel_i(bus_sel),
		.wdata_i(bus_wdata),
		.ready_o(ram_ready),
		.rdata_o(ram_rdata)
	);

	jbb_scratch_regs u_regs (
		.clk(clk),
		.reset(reset),
		.valid_i(reg_valid),
		.addr_i(bus_addr),
		.we_i(bus_we),
		.sel_i(bus_sel),
		.wdata_i(bus_wdata),
		.ready_o(reg_ready),
		.rdata_o(reg_rdata)
	);

endmodule

// File: verilog/jbb_word_ram.sv
`timescale 1ns/10ps

module jbb_word_ram (
	input  logic clk,
	input  logic valid_i,
	input  jbb_pkg::addr_t addr_i,
	input  logic we_i,
	input  jbb_pkg::sel_t sel_i,
	input  jbb_pkg::data_t wdata_i,
	output logic ready_o,
	output jbb_pkg::data_t rdata_o
);

	import jbb_pkg::*;

	data_t mem [RAM_DEPTH];
	logic [$clog2(RAM_DEPTH)-1:0] word_idx;

	// only the low bits index the array
	assign word_idx = addr_i[$clog2(RAM_DEPTH)-1:0];

	// single cycle access, never stalls
	assign ready_o = 1'b1;

	// --------------------
	// write port
	// --------------------

	always_ff @(posedge clk) begin
		if (valid_i && we_i) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (sel_i[i]) begin
					mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
				end
			end
		end
	end

	// --------------------
	// read port
	// --------------------

	// registered at acceptance, held until the next read
	always_ff @(posedge clk) begin
		if (valid_i && !we_i) begin
			rdata_o <= mem[word_idx];
		end
	end

endmodule
